// File: mem_stage_patterns.txt
// kind ctrl op vaddr csr dmw0 dmw1 cacop misc waddr wdata pc | comb flags waddr wdata pc excp paddr tidx
// kind 2 = tlb write: index in waddr, vppn in vaddr, ppn in wdata, {plv,d,v} in pc
2 0 0 00400000 0 00000000 00000000 00 0 00 00012345 0000000F 0 0 00 00000000 00000000 00 00000000 0
2 0 0 00401000 0 00000000 00000000 00 0 01 00000ABC 0000000C 0 0 00 00000000 00000000 00 00000000 0
2 0 0 00402000 0 00000000 00000000 00 0 02 00000DEF 00000003 0 0 00 00000000 00000000 00 00000000 0
2 0 0 00403000 0 00000000 00000000 00 0 03 00000777 0000000D 0 0 00 00000000 00000000 00 00000000 0
1 8 5 1C001234 1 A0000001 82000001 00 2 04 11111111 1C000010 0 C 04 11111111 1C000010 00 1C001234 0
1 8 9 A0001000 2 A0000001 82000001 00 0 00 CAFEF00D 1C000014 0 8 00 CAFEF00D 1C000014 00 00001000 0
1 8 1 80123456 2 A0000001 82000001 00 2 06 00000000 1C000018 0 C 06 00000000 1C000018 00 20123456 0
1 8 5 00400ABC 2 A0000001 82000001 00 2 07 00000000 1C00001C 1 C 07 00000000 1C00001C 00 12345ABC 0
1 8 4 00402010 2 A0000001 82000001 00 2 08 00000000 1C000020 1 C 08 00000000 1C000020 00 00DEF010 2
1 8 5 00500004 2 A0000001 82000001 00 2 09 00000000 1C000024 3 C 09 00000000 1C000024 0C 00000004 0
1 8 5 00401100 2 A0000001 82000001 00 2 0A 00000000 1C000028 3 C 0A 00000000 1C000028 08 00ABC100 1
1 8 9 00401200 2 A0000001 82000001 00 0 00 55AA55AA 1C00002C 3 8 00 55AA55AA 1C00002C 10 00ABC200 1
1 8 5 00402300 E A0000001 82000001 00 2 0B 00000000 1C000030 3 C 0B 00000000 1C000030 20 00DEF300 2
1 8 9 00403400 2 A0000001 82000001 00 0 00 12345678 1C000034 3 8 00 12345678 1C000034 40 00777400 3
1 8 5 80000010 E A0000001 82000001 00 2 0C 00000000 1C000038 3 C 0C 00000000 1C000038 0E 00000010 0
1 8 6 00001000 1 A0000001 82000001 00 2 0D 00000000 1C00003C 0 F 0D 00000000 1C00003C 00 00001000 0
1 8 A 00001000 1 A0000001 82000001 00 2 0E DEADBEEF 1C000040 0 E 0E 00000001 1C000040 00 00001000 0
1 8 A 00403000 2 A0000001 82000001 00 2 0F DEADBEEF 1C000044 0 E 0F 00000000 1C000044 00 00403000 3
1 8 6 00002000 1 A0000001 82000001 00 2 10 00000000 1C000048 0 F 10 00000000 1C000048 00 00002000 0
1 4 0 00000000 1 A0000001 82000001 00 0 00 00000000 1C00004C 0 0 00 00000000 1C00004C 00 00000000 0
1 8 A 00002000 1 A0000001 82000001 00 2 11 DEADBEEF 1C000050 0 E 11 00000000 1C000050 00 00002000 0
1 8 5 00003000 1 A0000001 82000001 00 2 12 13572468 1C000054 0 C 12 13572468 1C000054 00 00003000 0
1 9 5 00004000 1 A0000001 82000001 00 0 13 99999999 1C000058 0 4 12 13572468 1C000054 00 00003000 0
1 A 5 00005000 1 A0000001 82000001 00 3 14 77777777 1C00005C 2 0 00 00000000 00000000 00 00000000 0
1 8 5 00500000 2 A0000001 82000001 81 2 15 00000000 1C000060 4 C 15 00000000 1C000060 00 00500000 0
1 8 5 00500000 2 A0000001 82000001 90 2 16 00000000 1C000064 3 C 16 00000000 1C000064 0C 00000000 0
1 8 9 00500000 2 A0000001 82000001 88 0 00 00000000 1C000068 4 8 00 00000000 1C000068 00 00500000 0

// File: project.f
mem_pkg.sv
llbit_reg.sv
data_tlb.sv
addr_check.sv
mem_wb.sv
mem_stage_top.sv
mem_stage_checker.sv
mem_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PATTERNS  ?= mem_stage_patterns.txt
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mem_stage_tb.sv
module mem_stage_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int PAT_WORDS    = 20;
    localparam int MAX_PATTERNS = 64;

    logic clk;
    logic reset_i;
    logic mem_valid_i;
    mem_pkg::mem_op_e mem_op_i;
    logic [31:0] mem_vaddr_i;
    logic mem_we_i;
    logic [4:0] mem_waddr_i;
    logic [31:0] mem_wdata_i;
    logic [31:0] mem_pc_i;
    logic mem_excp_i;
    logic cacop_en_i;
    logic [4:0] cacop_op_i;
    logic csr_da_i;
    logic csr_pg_i;
    logic [1:0] csr_plv_i;
    logic [31:0] csr_dmw0_i;
    logic [31:0] csr_dmw1_i;
    logic csr_llbit_clear_i;
    logic stall_i;
    logic flush_i;
    logic tlb_we_i;
    logic [1:0] tlb_index_i;
    logic [19:0] tlb_vppn_i;
    logic [19:0] tlb_ppn_i;
    logic tlb_v_i;
    logic tlb_d_i;
    logic [1:0] tlb_plv_i;

    logic data_addr_trans_en_o;
    logic dcache_flush_o;
    logic cacop_mode_di_o;
    logic wb_valid_o;
    logic wb_we_o;
    logic [4:0] wb_waddr_o;
    logic [31:0] wb_wdata_o;
    logic [31:0] wb_pc_o;
    logic [6:0] wb_excp_o;
    logic [31:0] wb_paddr_o;
    logic [1:0] wb_tlb_index_o;
    logic wb_llbit_we_o;
    logic wb_llbit_value_o;

    // expected values handed to the checker
    logic check_en;
    logic [3:0] exp_comb;
    logic [3:0] exp_flags;
    logic [4:0] exp_waddr;
    logic [31:0] exp_wdata;
    logic [31:0] exp_pc;
    logic [6:0] exp_excp;
    logic [31:0] exp_paddr;
    logic [1:0] exp_tidx;
    int comb_errors;
    int wb_errors;

    logic [31:0] pattern_mem [0:PAT_WORDS*MAX_PATTERNS-1];
    int n_patterns;
    int other_errors;
    logic patterns_loaded;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    mem_stage_top uut (.*);

    mem_stage_checker u_check (
        .clk (clk), .reset_i (reset_i), .check_en_i (check_en),
        .exp_comb_i (exp_comb), .exp_flags_i (exp_flags), .exp_waddr_i (exp_waddr),
        .exp_wdata_i (exp_wdata), .exp_pc_i (exp_pc), .exp_excp_i (exp_excp),
        .exp_paddr_i (exp_paddr), .exp_tidx_i (exp_tidx),
        .trans_en_i (data_addr_trans_en_o), .dcache_flush_i (dcache_flush_o),
        .cacop_mode_di_i (cacop_mode_di_o), .wb_valid_i (wb_valid_o), .wb_we_i (wb_we_o),
        .wb_waddr_i (wb_waddr_o), .wb_wdata_i (wb_wdata_o), .wb_pc_i (wb_pc_o),
        .wb_excp_i (wb_excp_o), .wb_paddr_i (wb_paddr_o), .wb_tlb_index_i (wb_tlb_index_o),
        .wb_llbit_we_i (wb_llbit_we_o), .wb_llbit_value_i (wb_llbit_value_o),
        .comb_errors_o (comb_errors), .wb_errors_o (wb_errors)
    );

    // busy instruction on the mem inputs while reset is held
    task automatic drive_reset_inputs();
        mem_valid_i = 1'b1;
        mem_op_i = mem_pkg::OP_LD_W;
        mem_vaddr_i = 32'h1C000000;
        mem_we_i = 1'b1;
        mem_waddr_i = 5'h1F;
        mem_wdata_i = 32'hFFFFFFFF;
        mem_pc_i = 32'h1C000000;
        mem_excp_i = 1'b0;
        {cacop_en_i, cacop_op_i} = '0;
        {csr_da_i, csr_pg_i, csr_plv_i} = 4'b1000;
        {csr_dmw0_i, csr_dmw1_i} = '0;
        {csr_llbit_clear_i, stall_i, flush_i} = '0;
        {tlb_we_i, tlb_index_i, tlb_vppn_i, tlb_ppn_i, tlb_v_i, tlb_d_i, tlb_plv_i} = '0;
        check_en = 1'b0;
        {exp_comb, exp_flags, exp_waddr, exp_wdata, exp_pc, exp_excp, exp_paddr, exp_tidx} = '0;
    endtask

    // kind 1 is an instruction and kind 2 a tlb write
    task automatic apply_pattern(input int idx);
        int base;
        logic [31:0] ctrl;
        logic [31:0] csr;
        logic [31:0] cacop;
        logic [31:0] misc;
        base = idx * PAT_WORDS;
        ctrl = pattern_mem[base+1];
        csr = pattern_mem[base+4];
        cacop = pattern_mem[base+7];
        misc = pattern_mem[base+8];
        mem_valid_i = ctrl[3];
        csr_llbit_clear_i = ctrl[2];
        flush_i = ctrl[1];
        stall_i = ctrl[0];
        mem_op_i = mem_pkg::mem_op_e'(pattern_mem[base+2][3:0]);
        mem_vaddr_i = pattern_mem[base+3];
        {csr_plv_i, csr_pg_i, csr_da_i} = csr[3:0];
        csr_dmw0_i = pattern_mem[base+5];
        csr_dmw1_i = pattern_mem[base+6];
        cacop_en_i = cacop[7];
        cacop_op_i = cacop[4:0];
        mem_we_i = misc[1];
        mem_excp_i = misc[0];
        mem_waddr_i = pattern_mem[base+9][4:0];
        mem_wdata_i = pattern_mem[base+10];
        mem_pc_i = pattern_mem[base+11];
        tlb_we_i = (pattern_mem[base] == 32'd2);
        tlb_index_i = pattern_mem[base+9][1:0];
        tlb_vppn_i = pattern_mem[base+3][31:12];
        tlb_ppn_i = pattern_mem[base+10][19:0];
        {tlb_plv_i, tlb_d_i, tlb_v_i} = pattern_mem[base+11][3:0];
        check_en = (pattern_mem[base] == 32'd1);
        exp_comb = pattern_mem[base+12][3:0];
        exp_flags = pattern_mem[base+13][3:0];
        exp_waddr = pattern_mem[base+14][4:0];
        exp_wdata = pattern_mem[base+15];
        exp_pc = pattern_mem[base+16];
        exp_excp = pattern_mem[base+17][6:0];
        exp_paddr = pattern_mem[base+18];
        exp_tidx = pattern_mem[base+19][1:0];
    endtask

    initial begin
        other_errors = 0;
        patterns_loaded = 1'b0;
        reset_i = 1'b1;
        drive_reset_inputs();
        for (int i = 0; i < PAT_WORDS * MAX_PATTERNS; i++) begin
            pattern_mem[i] = '0;
        end
        $readmemh("mem_stage_patterns.txt", pattern_mem);
        n_patterns = 0;
        while (n_patterns < MAX_PATTERNS &&
               (pattern_mem[n_patterns*PAT_WORDS] == 32'd1 ||
                pattern_mem[n_patterns*PAT_WORDS] == 32'd2)) begin
            n_patterns++;
        end
        patterns_loaded = 1'b1;
        if (n_patterns == 0) begin
            $display("no patterns could be read from mem_stage_patterns.txt");
            other_errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        for (int i = 0; i < n_patterns; i++) begin
            apply_pattern(i);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        drive_reset_inputs();
        mem_valid_i = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        $display("errors: %0d combinational, %0d writeback, %0d other in %0d patterns",
                 comb_errors, wb_errors, other_errors, n_patterns);
        if (comb_errors + wb_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (patterns_loaded);
        #((n_patterns + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", n_patterns + 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: mem_stage_checker.sv
module mem_stage_checker (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        check_en_i,
    input  logic [3:0]  exp_comb_i,
    input  logic [3:0]  exp_flags_i,
    input  logic [4:0]  exp_waddr_i,
    input  logic [31:0] exp_wdata_i,
    input  logic [31:0] exp_pc_i,
    input  logic [6:0]  exp_excp_i,
    input  logic [31:0] exp_paddr_i,
    input  logic [1:0]  exp_tidx_i,
    input  logic        trans_en_i,
    input  logic        dcache_flush_i,
    input  logic        cacop_mode_di_i,
    input  logic        wb_valid_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_waddr_i,
    input  logic [31:0] wb_wdata_i,
    input  logic [31:0] wb_pc_i,
    input  logic [6:0]  wb_excp_i,
    input  logic [31:0] wb_paddr_i,
    input  logic [1:0]  wb_tlb_index_i,
    input  logic        wb_llbit_we_i,
    input  logic        wb_llbit_value_i,
    output int          comb_errors_o,
    output int          wb_errors_o
);

    int comb_errors = 0;
    int wb_errors = 0;

    logic        pend_en = 1'b0;
    logic        pend_reset = 1'b0;
    logic [3:0]  pend_flags;
    logic [4:0]  pend_waddr;
    logic [31:0] pend_wdata;
    logic [31:0] pend_pc;
    logic [6:0]  pend_excp;
    logic [31:0] pend_paddr;
    logic [1:0]  pend_tidx;

    assign comb_errors_o = comb_errors;
    assign wb_errors_o = wb_errors;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual, input bit is_wb);
        if (expected !== actual) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expected, actual);
            if (is_wb) begin
                wb_errors++;
            end else begin
                comb_errors++;
            end
        end
    endtask

    task automatic check_record(input logic [3:0] flags, input logic [4:0] waddr,
                                input logic [31:0] wdata, input logic [31:0] pc,
                                input logic [6:0] excp, input logic [31:0] paddr,
                                input logic [1:0] tidx);
        compare_value("wb_valid_o", 32'(flags[3]), 32'(wb_valid_i), 1'b1);
        compare_value("wb_we_o", 32'(flags[2]), 32'(wb_we_i), 1'b1);
        compare_value("wb_llbit_we_o", 32'(flags[1]), 32'(wb_llbit_we_i), 1'b1);
        compare_value("wb_llbit_value_o", 32'(flags[0]), 32'(wb_llbit_value_i), 1'b1);
        compare_value("wb_waddr_o", 32'(waddr), 32'(wb_waddr_i), 1'b1);
        compare_value("wb_wdata_o", wdata, wb_wdata_i, 1'b1);
        compare_value("wb_pc_o", pc, wb_pc_i, 1'b1);
        compare_value("wb_excp_o", 32'(excp), 32'(wb_excp_i), 1'b1);
        compare_value("wb_paddr_o", paddr, wb_paddr_i, 1'b1);
        compare_value("wb_tlb_index_o", 32'(tidx), 32'(wb_tlb_index_i), 1'b1);
    endtask

    // combinational outputs settle well before the next edge
    always @(negedge clk) begin
        if (check_en_i) begin
            compare_value("data_addr_trans_en_o", 32'(exp_comb_i[0]), 32'(trans_en_i), 1'b0);
            compare_value("dcache_flush_o", 32'(exp_comb_i[1]), 32'(dcache_flush_i), 1'b0);
            compare_value("cacop_mode_di_o", 32'(exp_comb_i[2]), 32'(cacop_mode_di_i), 1'b0);
        end
        pend_en <= check_en_i;
        pend_reset <= reset_i;
        pend_flags <= exp_flags_i;
        pend_waddr <= exp_waddr_i;
        pend_wdata <= exp_wdata_i;
        pend_pc <= exp_pc_i;
        pend_excp <= exp_excp_i;
        pend_paddr <= exp_paddr_i;
        pend_tidx <= exp_tidx_i;
    end

    // record is sampled just after the edge that loads it
    always @(posedge clk) begin
        #1;
        if (pend_reset) begin
            check_record(4'd0, 5'd0, 32'd0, 32'd0, 7'd0, 32'd0, 2'd0);
        end else if (pend_en) begin
            check_record(pend_flags, pend_waddr, pend_wdata, pend_pc, pend_excp,
                         pend_paddr, pend_tidx);
        end
    end

endmodule

// File: mem_stage_top.sv
module mem_stage_top (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           mem_valid_i,
    input  mem_pkg::mem_op_e               mem_op_i,
    input  logic [mem_pkg::XLEN-1:0]       mem_vaddr_i,
    input  logic                           mem_we_i,
    input  logic [4:0]                     mem_waddr_i,
    input  logic [mem_pkg::XLEN-1:0]       mem_wdata_i,
    input  logic [mem_pkg::XLEN-1:0]       mem_pc_i,
    input  logic                           mem_excp_i,
    input  logic                           cacop_en_i,
    input  logic [4:0]                     cacop_op_i,
    input  logic                           csr_da_i,
    input  logic                           csr_pg_i,
    input  logic [mem_pkg::PLV_W-1:0]      csr_plv_i,
    input  logic [mem_pkg::XLEN-1:0]       csr_dmw0_i,
    input  logic [mem_pkg::XLEN-1:0]       csr_dmw1_i,
    input  logic                           csr_llbit_clear_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  logic                           tlb_we_i,
    input  logic [mem_pkg::TLB_IDX_W-1:0]  tlb_index_i,
    input  logic [mem_pkg::VPPN_W-1:0]     tlb_vppn_i,
    input  logic [mem_pkg::PPN_W-1:0]      tlb_ppn_i,
    input  logic                           tlb_v_i,
    input  logic                           tlb_d_i,
    input  logic [mem_pkg::PLV_W-1:0]      tlb_plv_i,
    output logic                           data_addr_trans_en_o,
    output logic                           dcache_flush_o,
    output logic                           cacop_mode_di_o,
    output logic                           wb_valid_o,
    output logic                           wb_we_o,
    output logic [4:0]                     wb_waddr_o,
    output logic [mem_pkg::XLEN-1:0]       wb_wdata_o,
    output logic [mem_pkg::XLEN-1:0]       wb_pc_o,
    output logic [mem_pkg::EXCP_W-1:0]     wb_excp_o,
    output logic [mem_pkg::XLEN-1:0]       wb_paddr_o,
    output logic [mem_pkg::TLB_IDX_W-1:0]  wb_tlb_index_o,
    output logic                           wb_llbit_we_o,
    output logic                           wb_llbit_value_o
);

    logic                          llbit;
    logic                          tlb_found;
    logic                          tlb_v;
    logic                          tlb_d;
    logic [mem_pkg::PLV_W-1:0]     tlb_plv;
    logic [mem_pkg::PPN_W-1:0]     tlb_ppn;
    logic [mem_pkg::TLB_IDX_W-1:0] tlb_index;
    logic [mem_pkg::EXCP_W-1:0]    check_excp;
    logic [mem_pkg::EXCP_W-1:0]    excp_vec;
    logic [mem_pkg::XLEN-1:0]      paddr;

    llbit_reg u_llbit (
        .clk               (clk),
        .reset_i           (reset_i),
        .wb_llbit_we_i     (wb_llbit_we_o),
        .wb_llbit_value_i  (wb_llbit_value_o),
        .csr_llbit_clear_i (csr_llbit_clear_i),
        .llbit_o           (llbit)
    );

    data_tlb u_tlb (
        .clk           (clk),
        .reset_i       (reset_i),
        .lookup_vppn_i (mem_vaddr_i[mem_pkg::XLEN-1 -: mem_pkg::VPPN_W]),
        .we_i          (tlb_we_i),
        .windex_i      (tlb_index_i),
        .wvppn_i       (tlb_vppn_i),
        .wppn_i        (tlb_ppn_i),
        .wv_i          (tlb_v_i),
        .wd_i          (tlb_d_i),
        .wplv_i        (tlb_plv_i),
        .found_o       (tlb_found),
        .v_o           (tlb_v),
        .d_o           (tlb_d),
        .plv_o         (tlb_plv),
        .ppn_o         (tlb_ppn),
        .index_o       (tlb_index)
    );

    // access class is only needed inside the checker
    addr_check u_check (
        .valid_i         (mem_valid_i),
        .op_i            (mem_op_i),
        .vaddr_i         (mem_vaddr_i),
        .csr_da_i        (csr_da_i),
        .csr_pg_i        (csr_pg_i),
        .csr_plv_i       (csr_plv_i),
        .csr_dmw0_i      (csr_dmw0_i),
        .csr_dmw1_i      (csr_dmw1_i),
        .cacop_en_i      (cacop_en_i),
        .cacop_op_i      (cacop_op_i),
        .llbit_i         (llbit),
        .tlb_found_i     (tlb_found),
        .tlb_v_i         (tlb_v),
        .tlb_d_i         (tlb_d),
        .tlb_plv_i       (tlb_plv),
        .tlb_ppn_i       (tlb_ppn),
        .is_load_o       (),
        .is_store_o      (),
        .trans_en_o      (data_addr_trans_en_o),
        .cacop_mode_di_o (cacop_mode_di_o),
        .excp_o          (check_excp),
        .paddr_o         (paddr)
    );

    // upstream bit joins the memory exceptions
    always_comb begin
        excp_vec = check_excp;
        excp_vec[mem_pkg::EXCP_UP] = mem_excp_i;
    end

    assign dcache_flush_o = |excp_vec;

    mem_wb u_mem_wb (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .valid_i          (mem_valid_i),
        .op_i             (mem_op_i),
        .we_i             (mem_we_i),
        .waddr_i          (mem_waddr_i),
        .wdata_i          (mem_wdata_i),
        .pc_i             (mem_pc_i),
        .excp_i           (excp_vec),
        .paddr_i          (paddr),
        .tlb_index_i      (tlb_index),
        .llbit_i          (llbit),
        .wb_valid_o       (wb_valid_o),
        .wb_we_o          (wb_we_o),
        .wb_waddr_o       (wb_waddr_o),
        .wb_wdata_o       (wb_wdata_o),
        .wb_pc_o          (wb_pc_o),
        .wb_excp_o        (wb_excp_o),
        .wb_paddr_o       (wb_paddr_o),
        .wb_tlb_index_o   (wb_tlb_index_o),
        .wb_llbit_we_o    (wb_llbit_we_o),
        .wb_llbit_value_o (wb_llbit_value_o)
    );

endmodule

// File: mem_wb.sv
module mem_wb (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  logic                           valid_i,
    input  mem_pkg::mem_op_e               op_i,
    input  logic                           we_i,
    input  logic [4:0]                     waddr_i,
    input  logic [mem_pkg::XLEN-1:0]       wdata_i,
    input  logic [mem_pkg::XLEN-1:0]       pc_i,
    input  logic [mem_pkg::EXCP_W-1:0]     excp_i,
    input  logic [mem_pkg::XLEN-1:0]       paddr_i,
    input  logic [mem_pkg::TLB_IDX_W-1:0]  tlb_index_i,
    input  logic                           llbit_i,
    output logic                           wb_valid_o,
    output logic                           wb_we_o,
    output logic [4:0]                     wb_waddr_o,
    output logic [mem_pkg::XLEN-1:0]       wb_wdata_o,
    output logic [mem_pkg::XLEN-1:0]       wb_pc_o,
    output logic [mem_pkg::EXCP_W-1:0]     wb_excp_o,
    output logic [mem_pkg::XLEN-1:0]       wb_paddr_o,
    output logic [mem_pkg::TLB_IDX_W-1:0]  wb_tlb_index_o,
    output logic                           wb_llbit_we_o,
    output logic                           wb_llbit_value_o
);

    logic                     is_ll;
    logic                     is_sc;
    logic                     llbit_we;
    logic [mem_pkg::XLEN-1:0] wdata;

    assign is_ll    = (op_i == mem_pkg::OP_LL);
    assign is_sc    = (op_i == mem_pkg::OP_SC);
    assign llbit_we = valid_i && (excp_i == '0) && (is_ll || is_sc);

    // sc returns its success flag
    assign wdata = is_sc ? {{(mem_pkg::XLEN - 1){1'b0}}, llbit_i} : wdata_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wb_valid_o       <= 1'b0;
            wb_we_o          <= 1'b0;
            wb_waddr_o       <= '0;
            wb_wdata_o       <= '0;
            wb_pc_o          <= '0;
            wb_excp_o        <= '0;
            wb_paddr_o       <= '0;
            wb_tlb_index_o   <= '0;
            wb_llbit_we_o    <= 1'b0;
            wb_llbit_value_o <= 1'b0;
        end else if (stall_i) begin
            // insert a bubble and hold the rest of the record
            wb_valid_o    <= 1'b0;
            wb_llbit_we_o <= 1'b0;
        end else begin
            wb_valid_o       <= valid_i;
            wb_we_o          <= we_i;
            wb_waddr_o       <= waddr_i;
            wb_wdata_o       <= wdata;
            wb_pc_o          <= pc_i;
            wb_excp_o        <= excp_i;
            wb_paddr_o       <= paddr_i;
            wb_tlb_index_o   <= tlb_index_i;
            wb_llbit_we_o    <= llbit_we;
            wb_llbit_value_o <= is_ll;
        end
    end

endmodule

// File: addr_check.sv
module addr_check (
    input  logic                          valid_i,
    input  mem_pkg::mem_op_e              op_i,
    input  logic [mem_pkg::XLEN-1:0]      vaddr_i,
    input  logic                          csr_da_i,
    input  logic                          csr_pg_i,
    input  logic [mem_pkg::PLV_W-1:0]     csr_plv_i,
    input  logic [mem_pkg::XLEN-1:0]      csr_dmw0_i,
    input  logic [mem_pkg::XLEN-1:0]      csr_dmw1_i,
    input  logic                          cacop_en_i,
    input  logic [4:0]                    cacop_op_i,
    input  logic                          llbit_i,
    input  logic                          tlb_found_i,
    input  logic                          tlb_v_i,
    input  logic                          tlb_d_i,
    input  logic [mem_pkg::PLV_W-1:0]     tlb_plv_i,
    input  logic [mem_pkg::PPN_W-1:0]     tlb_ppn_i,
    output logic                          is_load_o,
    output logic                          is_store_o,
    output logic                          trans_en_o,
    output logic                          cacop_mode_di_o,
    output logic [mem_pkg::EXCP_W-1:0]    excp_o,
    output logic [mem_pkg::XLEN-1:0]      paddr_o
);

    logic access;
    logic pg_mode;
    logic dmw0_hit;
    logic dmw1_hit;
    logic plv0;
    logic plv3;

    assign is_load_o = (op_i == mem_pkg::OP_LD_B) || (op_i == mem_pkg::OP_LD_BU) ||
                       (op_i == mem_pkg::OP_LD_H) || (op_i == mem_pkg::OP_LD_HU) ||
                       (op_i == mem_pkg::OP_LD_W) || (op_i == mem_pkg::OP_LL);

    // sc only counts as a store while the ll bit holds
    assign is_store_o = (op_i == mem_pkg::OP_ST_B) || (op_i == mem_pkg::OP_ST_H) ||
                        (op_i == mem_pkg::OP_ST_W) || ((op_i == mem_pkg::OP_SC) && llbit_i);

    assign access = is_load_o || is_store_o;

    assign plv0 = (csr_plv_i == 2'd0);
    assign plv3 = (csr_plv_i == 2'd3);

    assign dmw0_hit = ((csr_dmw0_i[mem_pkg::DMW_PLV0] && plv0) ||
                       (csr_dmw0_i[mem_pkg::DMW_PLV3] && plv3)) &&
                      (vaddr_i[31:29] == csr_dmw0_i[mem_pkg::DMW_VSEG_HI:mem_pkg::DMW_VSEG_LO]);
    assign dmw1_hit = ((csr_dmw1_i[mem_pkg::DMW_PLV0] && plv0) ||
                       (csr_dmw1_i[mem_pkg::DMW_PLV3] && plv3)) &&
                      (vaddr_i[31:29] == csr_dmw1_i[mem_pkg::DMW_VSEG_HI:mem_pkg::DMW_VSEG_LO]);

    // cacop modes 0 and 1 index the cache directly
    assign cacop_mode_di_o = cacop_en_i && ((cacop_op_i[4:3] == 2'd0) || (cacop_op_i[4:3] == 2'd1));

    assign pg_mode    = csr_pg_i && !csr_da_i;
    assign trans_en_o = access && pg_mode && !dmw0_hit && !dmw1_hit && !cacop_mode_di_o && valid_i;

    always_comb begin
        excp_o = '0;
        excp_o[mem_pkg::EXCP_ADEM] = (access || cacop_en_i) && trans_en_o && plv3 && vaddr_i[31];
        excp_o[mem_pkg::EXCP_TLBR] = (access || cacop_en_i) && trans_en_o && !tlb_found_i;
        excp_o[mem_pkg::EXCP_PIL]  = is_load_o && trans_en_o && !tlb_v_i;
        excp_o[mem_pkg::EXCP_PIS]  = is_store_o && trans_en_o && !tlb_v_i;
        excp_o[mem_pkg::EXCP_PPI]  = access && trans_en_o && tlb_v_i && (csr_plv_i > tlb_plv_i);
        excp_o[mem_pkg::EXCP_PME]  = is_store_o && trans_en_o && tlb_v_i &&
                                     (csr_plv_i <= tlb_plv_i) && !tlb_d_i;
    end

    always_comb begin
        if (dmw0_hit) begin
            paddr_o = {csr_dmw0_i[mem_pkg::DMW_PSEG_HI:mem_pkg::DMW_PSEG_LO], vaddr_i[28:0]};
        end else if (dmw1_hit) begin
            paddr_o = {csr_dmw1_i[mem_pkg::DMW_PSEG_HI:mem_pkg::DMW_PSEG_LO], vaddr_i[28:0]};
        end else if (trans_en_o) begin
            paddr_o = {tlb_ppn_i, vaddr_i[11:0]};
        end else begin
            paddr_o = vaddr_i;
        end
    end

endmodule

// File: data_tlb.sv
module data_tlb (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [mem_pkg::VPPN_W-1:0]     lookup_vppn_i,
    input  logic                           we_i,
    input  logic [mem_pkg::TLB_IDX_W-1:0]  windex_i,
    input  logic [mem_pkg::VPPN_W-1:0]     wvppn_i,
    input  logic [mem_pkg::PPN_W-1:0]      wppn_i,
    input  logic                           wv_i,
    input  logic                           wd_i,
    input  logic [mem_pkg::PLV_W-1:0]      wplv_i,
    output logic                           found_o,
    output logic                           v_o,
    output logic                           d_o,
    output logic [mem_pkg::PLV_W-1:0]      plv_o,
    output logic [mem_pkg::PPN_W-1:0]      ppn_o,
    output logic [mem_pkg::TLB_IDX_W-1:0]  index_o
);

    logic [mem_pkg::TLB_ENTRIES-1:0] occupied;
    logic [mem_pkg::VPPN_W-1:0]      vppn_q [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::PPN_W-1:0]       ppn_q  [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::TLB_ENTRIES-1:0] v_q;
    logic [mem_pkg::TLB_ENTRIES-1:0] d_q;
    logic [mem_pkg::PLV_W-1:0]       plv_q  [mem_pkg::TLB_ENTRIES];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            occupied <= '0;
        end else if (we_i) begin
            occupied[windex_i] <= 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (we_i) begin
            vppn_q[windex_i] <= wvppn_i;
            ppn_q[windex_i]  <= wppn_i;
            v_q[windex_i]    <= wv_i;
            d_q[windex_i]    <= wd_i;
            plv_q[windex_i]  <= wplv_i;
        end
    end

    // walk from the top down so the lowest hit index wins
    always_comb begin
        found_o = 1'b0;
        v_o     = 1'b0;
        d_o     = 1'b0;
        plv_o   = '0;
        ppn_o   = '0;
        index_o = '0;
        for (int i = mem_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (occupied[i] && (vppn_q[i] == lookup_vppn_i)) begin
                found_o = 1'b1;
                v_o     = v_q[i];
                d_o     = d_q[i];
                plv_o   = plv_q[i];
                ppn_o   = ppn_q[i];
                index_o = mem_pkg::TLB_IDX_W'(i);
            end
        end
    end

endmodule

// File: llbit_reg.sv
module llbit_reg (
    input  logic clk,
    input  logic reset_i,
    input  logic wb_llbit_we_i,
    input  logic wb_llbit_value_i,
    input  logic csr_llbit_clear_i,
    output logic llbit_o
);

    logic llbit_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            llbit_q <= 1'b0;
        end else if (csr_llbit_clear_i) begin
            // csr clear beats a pending writeback
            llbit_q <= 1'b0;
        end else if (wb_llbit_we_i) begin
            llbit_q <= wb_llbit_value_i;
        end
    end

    // forward the value sitting in writeback
    assign llbit_o = wb_llbit_we_i ? wb_llbit_value_i : llbit_q;

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // memory opcodes seen by the memory stage
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_LD_B  = 4'h1,
        OP_LD_BU = 4'h2,
        OP_LD_H  = 4'h3,
        OP_LD_HU = 4'h4,
        OP_LD_W  = 4'h5,
        OP_LL    = 4'h6,
        OP_ST_B  = 4'h7,
        OP_ST_H  = 4'h8,
        OP_ST_W  = 4'h9,
        OP_SC    = 4'hA
    } mem_op_e;

    localparam int XLEN        = 32;
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = 2;
    localparam int VPPN_W      = 20;
    localparam int PPN_W       = 20;
    localparam int PLV_W       = 2;

    // exception vector layout
    localparam int EXCP_W    = 7;
    localparam int EXCP_UP   = 0;
    localparam int EXCP_ADEM = 1;
    localparam int EXCP_TLBR = 2;
    localparam int EXCP_PIL  = 3;
    localparam int EXCP_PIS  = 4;
    localparam int EXCP_PPI  = 5;
    localparam int EXCP_PME  = 6;

    // dmw csr fields
    localparam int DMW_PLV0    = 0;
    localparam int DMW_PLV3    = 3;
    localparam int DMW_PSEG_HI = 27;
    localparam int DMW_PSEG_LO = 25;
    localparam int DMW_VSEG_HI = 31;
    localparam int DMW_VSEG_LO = 29;

endpackage
